//--- src/rdp_pkg.sv
////////////////////////////////////////
// shared widths, color struct, combine
// operand codes and register map
////////////////////////////////////////
`default_nettype none

package rdp_pkg;

	////////////////////////////////////////
	// widths

	localparam int DATA_W     = 32;  // wishbone data
	localparam int ADDR_W     = 4;   // wishbone word address
	localparam int CHAN_W     = 8;   // one color channel
	localparam int COORD_W    = 12;  // pixel x and span length
	localparam int FRAC_W     = 4;   // shade accumulator fraction
	localparam int CC_LATENCY = 2;   // combiner pipeline depth

	localparam int SEL_W        = 3;   // one combine select
	localparam int COMBINE_W    = 12;  // four selects packed
	localparam int SPAN_LEN_LSB = 16;  // length field in span word

	////////////////////////////////////////
	// types

	// channel order matches the register word, r on top
	typedef struct packed {
		logic [CHAN_W-1:0] r;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] b;
		logic [CHAN_W-1:0] a;
	} rgba_t;

	typedef logic [CHAN_W+FRAC_W-1:0] shade_acc_t;  // 8.4 unsigned

	typedef enum logic [SEL_W-1:0] {
		SEL_ZERO  = 3'd0,
		SEL_SHADE = 3'd1,
		SEL_PRIM  = 3'd2,
		SEL_ENV   = 3'd3,
		SEL_ONE   = 3'd4   // 5..7 read as zero
	} cc_sel_e;

	////////////////////////////////////////
	// register map, word addresses

	typedef enum logic [ADDR_W-1:0] {
		REG_PRIM    = 4'd0,
		REG_ENV     = 4'd1,
		REG_COMBINE = 4'd2,  // a 2:0, b 5:3, c 8:6, d 11:9
		REG_SHADE   = 4'd3,  // rgba start value
		REG_DSHADE  = 4'd4,  // four s3.4 steps
		REG_SPAN    = 4'd5,  // x0 11:0, length 27:16
		REG_STATUS  = 4'd6   // busy in bit 0, read only
	} reg_addr_e;

endpackage

`default_nettype wire

//--- src/rdp_ifs.sv
////////////////////////////////////////
// mode and span interfaces with modports
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

// combine mode, static for the length of a span
interface mode_if import rdp_pkg::*; ();

	rgba_t   prim;   // primitive color
	rgba_t   env;    // environment color
	cc_sel_e sel_a;
	cc_sel_e sel_b;
	cc_sel_e sel_c;
	cc_sel_e sel_d;

	modport regs (
		output prim, env, sel_a, sel_b, sel_c, sel_d
	);

	modport combiner (
		input  prim, env, sel_a, sel_b, sel_c, sel_d
	);

endinterface

// span setup from the register block, busy back
interface span_if import rdp_pkg::*; ();

	logic               start;   // one cycle pulse
	logic [COORD_W-1:0] x0;
	logic [COORD_W-1:0] length;
	rgba_t              shade0;
	logic [DATA_W-1:0]  dshade;  // s3.4 per channel
	logic               busy;    // pixels out or combiner draining

	modport regs (
		output start, x0, length, shade0, dshade,
		input  busy
	);

	modport stepper (
		input  start, x0, length, shade0, dshade,
		output busy
	);

endinterface

`default_nettype wire

//--- src/rdp_cmd_regs.sv
////////////////////////////////////////
// wishbone classic slave, attribute
// registers and span start
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdp_cmd_regs import rdp_pkg::*; (
	input  logic              gclk,
	input  logic              arst_n,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [ADDR_W-1:0] wb_adr,
	input  logic [DATA_W-1:0] wb_wdata,
	output logic [DATA_W-1:0] wb_rdata,
	output logic              wb_ack,
	span_if.regs              span,
	mode_if.regs              mode
);

	rgba_t                prim_q;
	rgba_t                env_q;
	logic [COMBINE_W-1:0] combine_q;
	rgba_t                shade_q;
	logic [DATA_W-1:0]    dshade_q;
	logic [DATA_W-1:0]    span_q;
	logic                 start_q;

	logic                 req;
	logic                 stall;
	logic                 wr_fire;
	logic                 rd_fire;
	logic [DATA_W-1:0]    rd_mux;

	////////////////////////////////////////
	// bus handshake

	assign req     = wb_cyc & wb_stb & ~wb_ack;  // one ack per request
	assign stall   = span.busy | start_q;        // start not yet seen by stepper
	assign wr_fire = req & wb_we & ~stall;
	assign rd_fire = req & ~wb_we;               // reads never wait

	always_comb begin
		case (reg_addr_e'(wb_adr))
			REG_PRIM:    rd_mux = prim_q;
			REG_ENV:     rd_mux = env_q;
			REG_COMBINE: rd_mux = DATA_W'(combine_q);
			REG_SHADE:   rd_mux = shade_q;
			REG_DSHADE:  rd_mux = dshade_q;
			REG_SPAN:    rd_mux = span_q;
			REG_STATUS:  rd_mux = DATA_W'(span.busy);
			default:     rd_mux = '0;  // unmapped
		endcase
	end

	always_ff @(posedge gclk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack    <= 1'b0;
			wb_rdata  <= '0;
			start_q   <= 1'b0;
			prim_q    <= '0;
			env_q     <= '0;
			combine_q <= '0;
			shade_q   <= '0;
			dshade_q  <= '0;
			span_q    <= '0;
		end else begin
			wb_ack  <= wr_fire | rd_fire;
			start_q <= wr_fire && (reg_addr_e'(wb_adr) == REG_SPAN);
			if (rd_fire) begin
				wb_rdata <= rd_mux;
			end
			if (wr_fire) begin
				case (reg_addr_e'(wb_adr))
					REG_PRIM:    prim_q    <= rgba_t'(wb_wdata);
					REG_ENV:     env_q     <= rgba_t'(wb_wdata);
					REG_COMBINE: combine_q <= wb_wdata[COMBINE_W-1:0];
					REG_SHADE:   shade_q   <= rgba_t'(wb_wdata);
					REG_DSHADE:  dshade_q  <= wb_wdata;
					REG_SPAN:    span_q    <= wb_wdata;  // also kicks off the span
					default:     ;                       // status and holes
				endcase
			end
		end
	end

	////////////////////////////////////////
	// outputs to stepper and combiner

	assign span.start  = start_q;
	assign span.x0     = span_q[COORD_W-1:0];
	assign span.length = span_q[SPAN_LEN_LSB +: COORD_W];
	assign span.shade0 = shade_q;
	assign span.dshade = dshade_q;

	assign mode.prim  = prim_q;
	assign mode.env   = env_q;
	assign mode.sel_a = cc_sel_e'(combine_q[0*SEL_W +: SEL_W]);
	assign mode.sel_b = cc_sel_e'(combine_q[1*SEL_W +: SEL_W]);
	assign mode.sel_c = cc_sel_e'(combine_q[2*SEL_W +: SEL_W]);
	assign mode.sel_d = cc_sel_e'(combine_q[3*SEL_W +: SEL_W]);

endmodule

`default_nettype wire

//--- src/rdp_span_stepper.sv
////////////////////////////////////////
// shade stepper, x counter, busy/drain
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdp_span_stepper import rdp_pkg::*; (
	input  logic               gclk,
	input  logic               arst_n,
	span_if.stepper            span,
	output logic               pix_valid,
	output logic [COORD_W-1:0] pix_x,
	output rgba_t              pix_shade
);

	shade_acc_t                      acc_q [4];
	shade_acc_t                      acc_next [4];
	logic [CHAN_W+FRAC_W+1:0]        sum [4];    // two guard bits for clamp
	logic [COORD_W-1:0]              x_q;
	logic [COORD_W-1:0]              remain_q;   // pixels still to issue
	logic [$clog2(CC_LATENCY+1)-1:0] drain_q;
	logic                            busy_q;

	logic [3:0][CHAN_W-1:0]          start_ch;   // index 3 is red
	logic [3:0][CHAN_W-1:0]          step_ch;
	logic [3:0][CHAN_W-1:0]          shade_ch;

	assign start_ch = span.shade0;
	assign step_ch  = span.dshade;

	// add sign extended step, saturate to 0..4095
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			sum[i] = {2'b00, acc_q[i]} + {{(FRAC_W+2){step_ch[i][CHAN_W-1]}}, step_ch[i]};
			if (sum[i][CHAN_W+FRAC_W+1]) begin
				acc_next[i] = '0;        // went negative
			end else if (sum[i][CHAN_W+FRAC_W]) begin
				acc_next[i] = '1;        // past 255.9375
			end else begin
				acc_next[i] = sum[i][CHAN_W+FRAC_W-1:0];
			end
			shade_ch[i] = acc_q[i][CHAN_W+FRAC_W-1 -: CHAN_W];  // integer part
		end
	end

	////////////////////////////////////////
	// control: pixel count then drain

	always_ff @(posedge gclk or negedge arst_n) begin
		if (!arst_n) begin
			remain_q <= '0;
			drain_q  <= '0;
			busy_q   <= 1'b0;
		end else if (span.start) begin
			remain_q <= span.length;
			drain_q  <= $bits(drain_q)'(CC_LATENCY);
			busy_q   <= 1'b1;
		end else if (remain_q != '0) begin
			remain_q <= remain_q - 1'b1;
		end else if (drain_q != '0) begin
			drain_q <= drain_q - 1'b1;
			if (drain_q == 1'b1) begin
				busy_q <= 1'b0;  // last pixel has left the combiner
			end
		end
	end

	// accumulators and x
	always_ff @(posedge gclk) begin
		if (span.start) begin
			x_q <= span.x0;
			for (int i = 0; i < 4; i++) begin
				acc_q[i] <= {start_ch[i], {FRAC_W{1'b0}}};
			end
		end else if (remain_q != '0) begin
			x_q <= x_q + 1'b1;  // wraps at 4096
			for (int i = 0; i < 4; i++) begin
				acc_q[i] <= acc_next[i];
			end
		end
	end

	assign pix_valid = (remain_q != '0);
	assign pix_x     = x_q;
	assign pix_shade = shade_ch;
	assign span.busy = busy_q;

endmodule

`default_nettype wire

//--- src/rdp_color_combiner.sv
////////////////////////////////////////
// two stage color combiner (a-b)*c+d
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdp_color_combiner import rdp_pkg::*; (
	input  logic               gclk,
	input  logic               arst_n,
	input  logic               pix_valid,
	input  logic [COORD_W-1:0] pix_x,
	input  rgba_t              pix_shade,
	mode_if.combiner           mode,
	output logic               span_color_we,
	output logic [COORD_W-1:0] span_x,
	output rgba_t              span_color
);

	// operand for a, b and d, one is 255
	function automatic logic [CHAN_W-1:0] pick_abd(
		input cc_sel_e           sel,
		input logic [CHAN_W-1:0] shade,
		input logic [CHAN_W-1:0] prim,
		input logic [CHAN_W-1:0] env
	);
		case (sel)
			SEL_SHADE: return shade;
			SEL_PRIM:  return prim;
			SEL_ENV:   return env;
			SEL_ONE:   return '1;
			default:   return '0;
		endcase
	endfunction

	// c operand, one means 256 so the gain is unity
	function automatic logic [CHAN_W:0] pick_c(
		input cc_sel_e           sel,
		input logic [CHAN_W-1:0] shade,
		input logic [CHAN_W-1:0] prim,
		input logic [CHAN_W-1:0] env
	);
		case (sel)
			SEL_SHADE: return {1'b0, shade};
			SEL_PRIM:  return {1'b0, prim};
			SEL_ENV:   return {1'b0, env};
			SEL_ONE:   return {1'b1, {CHAN_W{1'b0}}};
			default:   return '0;
		endcase
	endfunction

	logic [3:0][CHAN_W-1:0]   shade_ch;
	logic [3:0][CHAN_W-1:0]   prim_ch;
	logic [3:0][CHAN_W-1:0]   env_ch;
	logic [3:0][CHAN_W-1:0]   op_a;
	logic [3:0][CHAN_W-1:0]   op_b;
	logic [3:0][CHAN_W:0]     op_c;
	logic [3:0][CHAN_W-1:0]   op_d;
	logic [3:0][CHAN_W:0]     diff;     // signed, -255..255

	logic                     s1_valid;
	logic [COORD_W-1:0]       s1_x;
	logic [3:0][CHAN_W:0]     s1_diff;
	logic [3:0][CHAN_W:0]     s1_c;
	logic [3:0][CHAN_W-1:0]   s1_d;

	logic [3:0][2*CHAN_W+2:0] prod;     // 9b signed times 10b signed
	logic [3:0][2*CHAN_W+2:0] shifted;
	logic [3:0][CHAN_W+1:0]   sum;      // signed, -255..510
	logic [3:0][CHAN_W-1:0]   result;

	assign shade_ch = pix_shade;
	assign prim_ch  = mode.prim;
	assign env_ch   = mode.env;

	////////////////////////////////////////
	// stage 1 operand select

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			op_a[i] = pick_abd(mode.sel_a, shade_ch[i], prim_ch[i], env_ch[i]);
			op_b[i] = pick_abd(mode.sel_b, shade_ch[i], prim_ch[i], env_ch[i]);
			op_c[i] = pick_c(mode.sel_c, shade_ch[i], prim_ch[i], env_ch[i]);
			op_d[i] = pick_abd(mode.sel_d, shade_ch[i], prim_ch[i], env_ch[i]);
			diff[i] = {1'b0, op_a[i]} - {1'b0, op_b[i]};
		end
	end

	////////////////////////////////////////
	// stage 2 multiply, shift, add, clamp

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			prod[i]    = $signed(s1_diff[i]) * $signed({1'b0, s1_c[i]});
			shifted[i] = $signed(prod[i]) >>> CHAN_W;  // floor divide by 256
			sum[i]     = shifted[i][CHAN_W+1:0] + {2'b00, s1_d[i]};
			if (sum[i][CHAN_W+1]) begin
				result[i] = '0;
			end else if (sum[i][CHAN_W]) begin
				result[i] = '1;
			end else begin
				result[i] = sum[i][CHAN_W-1:0];
			end
		end
	end

	always_ff @(posedge gclk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid      <= 1'b0;
			span_color_we <= 1'b0;
		end else begin
			s1_valid      <= pix_valid;
			span_color_we <= s1_valid;
		end
	end

	always_ff @(posedge gclk) begin
		s1_x       <= pix_x;
		s1_diff    <= diff;
		s1_c       <= op_c;
		s1_d       <= op_d;  // d taken with a, b, c
		span_x     <= s1_x;
		span_color <= result;
	end

endmodule

`default_nettype wire

//--- src/rdp_ms.sv
////////////////////////////////////////
// top level, registers to stepper to
// combiner
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdp_ms import rdp_pkg::*; (
	input  logic               gclk,
	input  logic               arst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [ADDR_W-1:0]  wb_adr,
	input  logic [DATA_W-1:0]  wb_wdata,
	output logic [DATA_W-1:0]  wb_rdata,
	output logic               wb_ack,
	output logic               span_color_we,
	output logic [COORD_W-1:0] span_x,
	output logic [CHAN_W-1:0]  span_r,
	output logic [CHAN_W-1:0]  span_g,
	output logic [CHAN_W-1:0]  span_b,
	output logic [CHAN_W-1:0]  span_a
);

	mode_if mode_bus ();
	span_if span_bus ();

	logic               pix_valid;
	logic [COORD_W-1:0] pix_x;
	rgba_t              pix_shade;
	rgba_t              span_color;

	rdp_cmd_regs u_cmd_regs (
		.gclk     (gclk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.span     (span_bus.regs),
		.mode     (mode_bus.regs)
	);

	rdp_span_stepper u_span_stepper (
		.gclk      (gclk),
		.arst_n    (arst_n),
		.span      (span_bus.stepper),
		.pix_valid (pix_valid),
		.pix_x     (pix_x),
		.pix_shade (pix_shade)
	);

	rdp_color_combiner u_color_combiner (
		.gclk          (gclk),
		.arst_n        (arst_n),
		.pix_valid     (pix_valid),
		.pix_x         (pix_x),
		.pix_shade     (pix_shade),
		.mode          (mode_bus.combiner),
		.span_color_we (span_color_we),
		.span_x        (span_x),
		.span_color    (span_color)
	);

	// channels out to the memory side
	assign span_r = span_color.r;
	assign span_g = span_color.g;
	assign span_b = span_color.b;
	assign span_a = span_color.a;

endmodule

`default_nettype wire

//--- tests/tb_rdp_ms.sv
////////////////////////////////////////
// testbench for rdp_ms: random spans,
// reference model, checks and watchdog
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_rdp_ms import rdp_pkg::*; ();

	localparam int CLK_PERIOD      = 40;
	localparam int MAX_LEN         = 32;  // longest random span
	localparam int NUM_SPANS       = 39;  // spans started over the whole run
	localparam int WATCHDOG_CYCLES = NUM_SPANS * (MAX_LEN + 20) + 200;
	localparam int ACK_LIMIT       = MAX_LEN + 20;
	localparam logic [ADDR_W-1:0] ADDR_HOLE = 4'd7;  // unmapped, used as a barrier

	logic               gclk;
	logic               arst_n;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic [ADDR_W-1:0]  wb_adr;
	logic [DATA_W-1:0]  wb_wdata;
	logic [DATA_W-1:0]  wb_rdata;
	logic               wb_ack;
	logic               span_color_we;
	logic [COORD_W-1:0] span_x;
	logic [CHAN_W-1:0]  span_r;
	logic [CHAN_W-1:0]  span_g;
	logic [CHAN_W-1:0]  span_b;
	logic [CHAN_W-1:0]  span_a;

	logic [31:0] lfsr_state;
	logic [43:0] exp_q [$];  // {x, rgba} predicted
	logic [43:0] got_q [$];  // {x, rgba} seen at the output

	rdp_ms uut (
		.gclk          (gclk),
		.arst_n        (arst_n),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_wdata      (wb_wdata),
		.wb_rdata      (wb_rdata),
		.wb_ack        (wb_ack),
		.span_color_we (span_color_we),
		.span_x        (span_x),
		.span_r        (span_r),
		.span_g        (span_g),
		.span_b        (span_b),
		.span_a        (span_a)
	);

	initial begin
		gclk = 1'b0;
		forever #(CLK_PERIOD / 2) gclk = ~gclk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge gclk);
		abort_run("timeout: the watchdog expired before the tests finished");
	end

	// outputs are stable mid cycle
	always @(negedge gclk) begin
		if (arst_n && span_color_we) begin
			got_q.push_back({span_x, span_r, span_g, span_b, span_a});
		end
	end

	////////////////////////////////////////
	// helpers

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;  // galois taps 32 22 2 1
		end else begin
			return s >> 1;
		end
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r          = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return r;
	endfunction

	task automatic write_reg(input logic [ADDR_W-1:0] adr, input logic [31:0] data);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_wdata = data;
		@(negedge gclk);
		while (!wb_ack) begin
			waited++;
			if (waited > ACK_LIMIT) begin
				abort_run($sformatf("timeout: no ack for the write to address %0d", adr));
			end
			@(negedge gclk);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] adr, output logic [31:0] data);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		@(negedge gclk);
		while (!wb_ack) begin
			waited++;
			if (waited > ACK_LIMIT) begin
				abort_run($sformatf("timeout: no ack for the read of address %0d", adr));
			end
			@(negedge gclk);
		end
		data   = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// writes stall while busy, so an ignored write waits for the span to drain
	task automatic wait_idle();
		write_reg(ADDR_HOLE, 32'h0);
	endtask

	////////////////////////////////////////
	// reference model

	function automatic int operand(input logic [2:0] sel, input int shade, input int prim,
			input int env, input bit is_c);
		case (sel)
			3'd1:    return shade;
			3'd2:    return prim;
			3'd3:    return env;
			3'd4:    return is_c ? 256 : 255;  // unity gain on c
			default: return 0;
		endcase
	endfunction

	function automatic int combine_channel(input logic [11:0] mode, input int shade,
			input int prim, input int env);
		int a;
		int b;
		int c;
		int d;
		int v;
		a = operand(mode[2:0], shade, prim, env, 1'b0);
		b = operand(mode[5:3], shade, prim, env, 1'b0);
		c = operand(mode[8:6], shade, prim, env, 1'b1);
		d = operand(mode[11:9], shade, prim, env, 1'b0);
		v = (((a - b) * c) >>> 8) + d;  // floor shift
		if (v < 0) begin
			v = 0;
		end else if (v > 255) begin
			v = 255;
		end
		return v;
	endfunction

	task automatic model_span(input logic [31:0] prim, input logic [31:0] env,
			input logic [11:0] mode, input logic [31:0] shade, input logic [31:0] dshade,
			input logic [11:0] x0, input logic [11:0] len);
		int          acc [4];
		logic [31:0] color;
		logic [11:0] x;
		for (int c = 0; c < 4; c++) begin
			acc[c] = int'(shade[c*8 +: 8]) << 4;  // 8.4
		end
		x = x0;
		for (int k = 0; k < len; k++) begin
			for (int c = 0; c < 4; c++) begin
				color[c*8 +: 8] = combine_channel(mode, acc[c] >> 4,
					int'(prim[c*8 +: 8]), int'(env[c*8 +: 8]));
				acc[c] = acc[c] + int'($signed(dshade[c*8 +: 8]));
				if (acc[c] < 0) begin
					acc[c] = 0;
				end else if (acc[c] > 4095) begin
					acc[c] = 4095;
				end
			end
			exp_q.push_back({x, color});
			x = x + 1'b1;  // wraps at 4096
		end
	endtask

	task automatic check_pixels(input string name);
		logic [43:0] e;
		logic [43:0] g;
		if (got_q.size() != exp_q.size()) begin
			abort_run($sformatf("%s: expected %0d pixels but the DUT wrote %0d",
				name, exp_q.size(), got_q.size()));
		end
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			check_value({name, " x"}, {20'h0, e[43:32]}, {20'h0, g[43:32]});
			check_value({name, " color"}, e[31:0], g[31:0]);
		end
	endtask

	task automatic setup_mode(input logic [31:0] prim, input logic [31:0] env,
			input logic [11:0] mode, input logic [31:0] shade, input logic [31:0] dshade);
		write_reg(REG_PRIM, prim);
		write_reg(REG_ENV, env);
		write_reg(REG_COMBINE, {20'h0, mode});
		write_reg(REG_SHADE, shade);
		write_reg(REG_DSHADE, dshade);
	endtask

	task automatic run_span(input string name, input logic [31:0] prim, input logic [31:0] env,
			input logic [11:0] mode, input logic [31:0] shade, input logic [31:0] dshade,
			input logic [11:0] x0, input logic [11:0] len);
		setup_mode(prim, env, mode, shade, dshade);
		model_span(prim, env, mode, shade, dshade, x0, len);
		write_reg(REG_SPAN, {4'h0, len, 4'h0, x0});
		wait_idle();
		check_pixels(name);
	endtask

	////////////////////////////////////////
	// test sequence

	initial begin
		logic [31:0] words [6];
		logic [31:0] data;
		logic [31:0] prim;
		logic [31:0] shade;
		logic [11:0] len;
		logic [11:0] total;

		lfsr_state = 32'd91;
		arst_n     = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_wdata   = '0;
		repeat (3) @(posedge gclk);
		@(negedge gclk);
		arst_n = 1'b1;
		check_value("reset ack", 32'h0, {31'h0, wb_ack});
		check_value("reset we", 32'h0, {31'h0, span_color_we});

		// 1: readback, span word carries length 0
		for (int i = 0; i < 6; i++) begin
			words[i] = rand_bits(32);
		end
		words[int'(REG_SPAN)][27:16] = 12'h0;
		for (int i = 0; i < 6; i++) begin
			write_reg(4'(i), words[i]);
		end
		wait_idle();
		for (int i = 0; i < 6; i++) begin
			read_reg(4'(i), data);
			check_value($sformatf("readback %0d", i),
				(i == int'(REG_COMBINE)) ? (words[i] & 32'hfff) : words[i], data);
		end
		read_reg(REG_STATUS, data);
		check_value("status idle", 32'h0, data);
		for (int a = 7; a < 16; a++) begin
			read_reg(4'(a), data);
			check_value($sformatf("unmapped %0d", a), 32'h0, data);
		end
		check_pixels("zero length readback span");

		// 2: shade pass through, last span wraps x
		for (int n = 0; n < 4; n++) begin
			run_span($sformatf("shade span %0d", n), rand_bits(32), rand_bits(32), 12'h101,
				rand_bits(32), rand_bits(32), (n == 3) ? 12'hffa : rand_bits(12),
				(n == 3) ? 12'(MAX_LEN) : 12'(1 + rand_bits(5)));
		end

		// 3: random selects, codes 5..7 included
		for (int n = 0; n < 24; n++) begin
			run_span($sformatf("combine span %0d", n), rand_bits(32), rand_bits(32),
				rand_bits(12), rand_bits(32), rand_bits(32), rand_bits(12),
				12'(1 + rand_bits(5)));
		end

		// 4: stepper saturation both ways, then output saturation
		shade = rand_bits(32) | 32'h1010_1010;
		setup_mode(rand_bits(32), rand_bits(32), 12'h101, shade, 32'h7f7f_7f7f);
		model_span(32'h0, 32'h0, 12'h101, shade, 32'h7f7f_7f7f, rand_bits(12), MAX_LEN);
		write_reg(REG_SPAN, {4'h0, 12'(MAX_LEN), 4'h0, exp_q[0][43:32]});
		wait_idle();
		check_value("clamp high last", 32'hffff_ffff, got_q[got_q.size()-1][31:0]);
		check_pixels("clamp high");
		shade = rand_bits(32) & 32'h7f7f_7f7f;
		setup_mode(rand_bits(32), rand_bits(32), 12'h101, shade, 32'h8080_8080);
		model_span(32'h0, 32'h0, 12'h101, shade, 32'h8080_8080, rand_bits(12), MAX_LEN);
		write_reg(REG_SPAN, {4'h0, 12'(MAX_LEN), 4'h0, exp_q[0][43:32]});
		wait_idle();
		check_value("clamp low last", 32'h0, got_q[got_q.size()-1][31:0]);
		check_pixels("clamp low");
		prim = rand_bits(32) | 32'h0101_0101;  // nonzero d pushes past 255
		run_span("output saturate", prim, rand_bits(32), 12'h504, rand_bits(32),
			rand_bits(32), rand_bits(12), 12'(1 + rand_bits(5)));

		// 5: prim write right after the span word stalls until drained
		prim  = rand_bits(32);
		shade = rand_bits(32);
		len   = 12'(1 + rand_bits(5));
		setup_mode(prim, 32'h0, 12'h102, shade, 32'h0);
		model_span(prim, 32'h0, 12'h102, shade, 32'h0, 12'h100, len);
		write_reg(REG_SPAN, {4'h0, len, 4'h0, 12'h100});
		write_reg(REG_PRIM, ~prim);
		check_value("stall pixel count", {20'h0, len}, got_q.size());
		wait_idle();
		check_pixels("write stall");

		// 6: back to back spans, some of length 0
		prim  = rand_bits(32);
		shade = rand_bits(32);
		data  = rand_bits(32);
		total = 12'h0;
		setup_mode(prim, 32'h0, 12'h101, shade, data);
		for (int n = 0; n < 6; n++) begin
			len = (n % 2 == 1 || n == 4) ? 12'h0 : 12'(1 + rand_bits(5));
			model_span(prim, 32'h0, 12'h101, shade, data, 12'(n * 64), len);
			write_reg(REG_SPAN, {4'h0, len, 4'h0, 12'(n * 64)});
			total = total + len;
		end
		wait_idle();
		check_value("back to back count", {20'h0, total}, got_q.size());
		check_pixels("back to back");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
src/rdp_pkg.sv
src/rdp_ifs.sv
src/rdp_cmd_regs.sv
src/rdp_span_stepper.sv
src/rdp_color_combiner.sv
src/rdp_ms.sv
tests/tb_rdp_ms.sv
